// ==== common/vecmat_pkg.sv ====
package vecmat_pkg;

  // ==============================
  // Widths
  // ==============================
  localparam int DATA_W     = 16;  // Q8.8 element.
  localparam int FRAC_W     = 8;
  localparam int AXI_ADDR_W = 12;
  localparam int AXI_DATA_W = 32;

  localparam logic signed [DATA_W-1:0] SAT_MAX = 16'sh7fff;
  localparam logic signed [DATA_W-1:0] SAT_MIN = 16'sh8000;

  // ==============================
  // Register map
  // ==============================
  localparam logic [AXI_ADDR_W-1:0] CTRL_ADDR   = 12'h000;  // Bit 0 starts.
  localparam logic [AXI_ADDR_W-1:0] STATUS_ADDR = 12'h004;  // Busy, done, saturated.
  localparam logic [AXI_ADDR_W-1:0] RESULT_ADDR = 12'h008;
  localparam logic [AXI_ADDR_W-1:0] VEC_BASE    = 12'h100;
  localparam logic [AXI_ADDR_W-1:0] WGT_BASE    = 12'h200;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DONE
  } ctrl_state_t;

  // Clamp a wide intermediate to the element range.
  function automatic logic signed [DATA_W-1:0] clamp(input logic signed [2*DATA_W-1:0] v);
    if (v > SAT_MAX) return SAT_MAX;
    if (v < SAT_MIN) return SAT_MIN;
    return v[DATA_W-1:0];
  endfunction

  function automatic logic out_of_range(input logic signed [2*DATA_W-1:0] v);
    return (v > SAT_MAX) || (v < SAT_MIN);
  endfunction

  function automatic logic signed [2*DATA_W-1:0] wide_sum(input logic signed [DATA_W-1:0] a,
                                                           input logic signed [DATA_W-1:0] b);
    return (2*DATA_W)'(a) + (2*DATA_W)'(b);
  endfunction

  // Full product, then arithmetic shift back to Q8.8 (floor).
  function automatic logic signed [2*DATA_W-1:0] wide_prod(input logic signed [DATA_W-1:0] a,
                                                            input logic signed [DATA_W-1:0] b);
    logic signed [2*DATA_W-1:0] p;
    p = (2*DATA_W)'(a) * (2*DATA_W)'(b);
    return p >>> FRAC_W;
  endfunction

  function automatic logic signed [DATA_W-1:0] sat_add(input logic signed [DATA_W-1:0] a,
                                                       input logic signed [DATA_W-1:0] b);
    return clamp(wide_sum(a, b));
  endfunction

  function automatic logic is_add_sat(input logic signed [DATA_W-1:0] a,
                                      input logic signed [DATA_W-1:0] b);
    return out_of_range(wide_sum(a, b));
  endfunction

  function automatic logic signed [DATA_W-1:0] sat_mul(input logic signed [DATA_W-1:0] a,
                                                       input logic signed [DATA_W-1:0] b);
    return clamp(wide_prod(a, b));
  endfunction

  function automatic logic is_mul_sat(input logic signed [DATA_W-1:0] a,
                                      input logic signed [DATA_W-1:0] b);
    return out_of_range(wide_prod(a, b));
  endfunction

endpackage

// ==== vecmat/vecmat_mul.sv ====
module vecmat_mul import vecmat_pkg::*; #(
  parameter int VEC_LEN = 8
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      launch,
  input  logic [VEC_LEN*DATA_W-1:0] vec_flat,
  input  logic [VEC_LEN*DATA_W-1:0] wgt_flat,
  output logic [VEC_LEN*DATA_W-1:0] prod_flat,
  output logic                      prod_valid,
  output logic                      prod_sat
);

  logic [VEC_LEN*DATA_W-1:0] prod_next;
  logic [VEC_LEN-1:0]        ovf;

  // One saturating multiplier per element pair.
  always_comb begin
    for (int i = 0; i < VEC_LEN; i++) begin
      prod_next[i*DATA_W +: DATA_W] = sat_mul(vec_flat[i*DATA_W +: DATA_W],
                                              wgt_flat[i*DATA_W +: DATA_W]);
      ovf[i] = is_mul_sat(vec_flat[i*DATA_W +: DATA_W],
                          wgt_flat[i*DATA_W +: DATA_W]);
    end
  end

  always_ff @(posedge clk) begin
    if (launch) begin
      prod_flat <= prod_next;
    end
  end

  always_ff @(posedge clk) begin
    if (!reset) begin
      prod_valid <= 1'b0;
      prod_sat   <= 1'b0;
    end else begin
      prod_valid <= launch;
      prod_sat   <= launch && (|ovf);  // Pulse aligned with prod_valid.
    end
  end

endmodule

// ==== vecmat/vecmat_add.sv ====
module vecmat_add import vecmat_pkg::*; #(
  parameter int VEC_LEN    = 8,
  parameter int PIPE_EVERY = 2
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [VEC_LEN*DATA_W-1:0] prod_flat,
  input  logic                      prod_valid,
  input  logic                      prod_sat,
  output logic [DATA_W-1:0]         sum,
  output logic                      sum_valid,
  output logic                      sum_sat
);

  // A single element still gets one pass-through level.
  localparam int LEVELS = (VEC_LEN > 1) ? $clog2(VEC_LEN) : 1;
  localparam int STAGES = (LEVELS + PIPE_EVERY - 1) / PIPE_EVERY;

  // ==============================
  // Reduction levels
  // ==============================
  genvar lv;
  for (lv = 0; lv < LEVELS; lv++) begin : lvl
    localparam int N_IN  = (VEC_LEN + (1 << lv) - 1) >> lv;
    localparam int N_OUT = (N_IN + 1) / 2;
    localparam bit REG   = ((lv + 1) % PIPE_EVERY == 0) || (lv == LEVELS - 1);

    logic [N_IN*DATA_W-1:0]  din;
    logic                    vin;
    logic                    sin;
    logic [N_OUT*DATA_W-1:0] nxt;
    logic                    nsat;
    logic [N_OUT*DATA_W-1:0] dout;
    logic                    vout;
    logic                    sout;

    if (lv == 0) begin : g_src
      assign din = prod_flat;
      assign vin = prod_valid;
      assign sin = prod_sat;
    end else begin : g_src
      assign din = lvl[lv-1].dout;
      assign vin = lvl[lv-1].vout;
      assign sin = lvl[lv-1].sout;
    end

    always_comb begin
      nsat = sin;
      for (int k = 0; k < N_OUT; k++) begin
        if (2*k + 1 < N_IN) begin
          nxt[k*DATA_W +: DATA_W] = sat_add(din[2*k*DATA_W +: DATA_W],
                                            din[(2*k+1)*DATA_W +: DATA_W]);
          if (vin && is_add_sat(din[2*k*DATA_W +: DATA_W],
                                din[(2*k+1)*DATA_W +: DATA_W])) begin
            nsat = 1'b1;
          end
        end else begin
          nxt[k*DATA_W +: DATA_W] = din[2*k*DATA_W +: DATA_W];  // Odd last node.
        end
      end
    end

    if (REG) begin : g_reg
      always_ff @(posedge clk) begin
        dout <= nxt;
      end

      always_ff @(posedge clk) begin
        if (!reset) begin
          vout <= 1'b0;
          sout <= 1'b0;
        end else begin
          vout <= vin;
          sout <= nsat;
        end
      end
    end else begin : g_comb
      assign dout = nxt;
      assign vout = vin;
      assign sout = nsat;
    end
  end

  assign sum       = lvl[LEVELS-1].dout;
  assign sum_valid = lvl[LEVELS-1].vout;
  assign sum_sat   = lvl[LEVELS-1].sout;

  // Valid bits march through the tree with their data.
  a_latency: assert property (@(posedge clk) disable iff (!reset)
    sum_valid == $past(prod_valid, STAGES))
    else $error("sum_valid not aligned to prod_valid after %0d stages", STAGES);

endmodule

// ==== src/axil_regs.sv ====
module axil_regs import vecmat_pkg::*; #(
  parameter int VEC_LEN = 8
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [AXI_ADDR_W-1:0]     awaddr,
  input  logic                      awvalid,
  output logic                      awready,
  input  logic [AXI_DATA_W-1:0]     wdata,
  input  logic                      wvalid,
  output logic                      wready,
  output logic [1:0]                bresp,
  output logic                      bvalid,
  input  logic                      bready,
  input  logic [AXI_ADDR_W-1:0]     araddr,
  input  logic                      arvalid,
  output logic                      arready,
  output logic [AXI_DATA_W-1:0]     rdata,
  output logic [1:0]                rresp,
  output logic                      rvalid,
  input  logic                      rready,
  output logic                      launch,
  output logic [VEC_LEN*DATA_W-1:0] vec_flat,
  output logic [VEC_LEN*DATA_W-1:0] wgt_flat,
  input  logic [DATA_W-1:0]         sum,
  input  logic                      sum_valid,
  input  logic                      sum_sat
);

  localparam int IDX_W = 6;  // Element index lives in addr[7:2].

  ctrl_state_t           state;
  logic [DATA_W-1:0]     result;
  logic                  sat_flag;
  logic                  wr_en;
  logic                  rd_en;
  logic                  wr_vec;
  logic                  wr_wgt;
  logic                  wr_ok;
  logic                  start;
  logic [IDX_W-1:0]      wr_idx;
  logic [IDX_W-1:0]      rd_idx;
  logic [AXI_DATA_W-1:0] rd_data;
  logic                  rd_ok;

  function automatic logic elem_hit(input logic [AXI_ADDR_W-1:0] addr,
                                    input logic [AXI_ADDR_W-1:0] base);
    return (addr[AXI_ADDR_W-1:8] == base[AXI_ADDR_W-1:8]) && (addr[1:0] == 2'b00) &&
           (int'(addr[7:2]) < VEC_LEN);
  endfunction

  function automatic logic [AXI_DATA_W-1:0] sext(input logic [DATA_W-1:0] v);
    return {{(AXI_DATA_W-DATA_W){v[DATA_W-1]}}, v};
  endfunction

  // ==============================
  // Address decode
  // ==============================
  assign wr_en  = awready && awvalid && wready && wvalid;
  assign rd_en  = arready && arvalid;
  assign wr_idx = awaddr[7:2];
  assign rd_idx = araddr[7:2];
  assign wr_vec = elem_hit(awaddr, VEC_BASE);
  assign wr_wgt = elem_hit(awaddr, WGT_BASE);
  assign wr_ok  = wr_vec || wr_wgt || (awaddr == CTRL_ADDR) ||
                  (awaddr == STATUS_ADDR) || (awaddr == RESULT_ADDR);
  assign start  = wr_en && (awaddr == CTRL_ADDR) && wdata[0];

  always_comb begin
    rd_ok   = 1'b1;
    rd_data = '0;
    if (elem_hit(araddr, VEC_BASE)) begin
      rd_data = sext(vec_flat[rd_idx*DATA_W +: DATA_W]);
    end else if (elem_hit(araddr, WGT_BASE)) begin
      rd_data = sext(wgt_flat[rd_idx*DATA_W +: DATA_W]);
    end else if (araddr == STATUS_ADDR) begin
      rd_data = {{(AXI_DATA_W-3){1'b0}}, sat_flag, state == DONE, state == RUN};
    end else if (araddr == RESULT_ADDR) begin
      rd_data = sext(result);
    end else if (araddr != CTRL_ADDR) begin
      rd_ok = 1'b0;  // Unmapped, data stays 0.
    end
  end

  // ==============================
  // Write and read channels
  // ==============================
  always_ff @(posedge clk) begin
    if (!reset) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      awready <= awvalid && wvalid && !bvalid && !awready;  // One-cycle accept.
      wready  <= awvalid && wvalid && !bvalid && !awready;
      arready <= arvalid && !rvalid && !arready;
      if (wr_en) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
      if (rd_en) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      bresp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
    end
    if (rd_en) begin
      rdata <= rd_data;
      rresp <= rd_ok ? RESP_OKAY : RESP_SLVERR;
    end
  end

  // Operand banks.
  always_ff @(posedge clk) begin
    if (!reset) begin
      vec_flat <= '0;
      wgt_flat <= '0;
    end else begin
      if (wr_en && wr_vec) vec_flat[wr_idx*DATA_W +: DATA_W] <= wdata[DATA_W-1:0];
      if (wr_en && wr_wgt) wgt_flat[wr_idx*DATA_W +: DATA_W] <= wdata[DATA_W-1:0];
    end
  end

  // ==============================
  // Control FSM
  // ==============================
  always_ff @(posedge clk) begin
    if (!reset) begin
      state    <= IDLE;
      launch   <= 1'b0;
      sat_flag <= 1'b0;
      result   <= '0;
    end else begin
      launch <= 1'b0;
      if (start && state != RUN) begin  // Start while RUN is dropped.
        state    <= RUN;
        launch   <= 1'b1;
        sat_flag <= 1'b0;
      end else if (sum_valid) begin
        state    <= DONE;
        result   <= sum;
        sat_flag <= sum_sat;
      end
    end
  end

  a_bhold: assert property (@(posedge clk) disable iff (!reset)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else $error("write response dropped or changed before bready");

  a_rhold: assert property (@(posedge clk) disable iff (!reset)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else $error("read response dropped or changed before rready");

  a_sum_run: assert property (@(posedge clk) disable iff (!reset)
    sum_valid |-> state == RUN)
    else $error("tree result arrived outside RUN");

endmodule

// ==== src/vecmat_unit.sv ====
module vecmat_unit import vecmat_pkg::*; #(
  parameter int VEC_LEN    = 8,
  parameter int PIPE_EVERY = 2
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [AXI_ADDR_W-1:0] awaddr,
  input  logic                  awvalid,
  output logic                  awready,
  input  logic [AXI_DATA_W-1:0] wdata,
  input  logic                  wvalid,
  output logic                  wready,
  output logic [1:0]            bresp,
  output logic                  bvalid,
  input  logic                  bready,
  input  logic [AXI_ADDR_W-1:0] araddr,
  input  logic                  arvalid,
  output logic                  arready,
  output logic [AXI_DATA_W-1:0] rdata,
  output logic [1:0]            rresp,
  output logic                  rvalid,
  input  logic                  rready
);

  logic                      launch;
  logic [VEC_LEN*DATA_W-1:0] vec_flat;
  logic [VEC_LEN*DATA_W-1:0] wgt_flat;
  logic [VEC_LEN*DATA_W-1:0] prod_flat;
  logic                      prod_valid;
  logic                      prod_sat;
  logic [DATA_W-1:0]         sum;
  logic                      sum_valid;
  logic                      sum_sat;

  // Register block, then multipliers, then the tree back into the registers.
  axil_regs #(
    .VEC_LEN(VEC_LEN)
  ) u_regs (.*);

  vecmat_mul #(
    .VEC_LEN(VEC_LEN)
  ) u_mul (.*);

  vecmat_add #(
    .VEC_LEN   (VEC_LEN),
    .PIPE_EVERY(PIPE_EVERY)
  ) u_add (.*);

endmodule

// ==== tb/vecmat_tb.sv ====
module vecmat_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int VEC_LEN    = 8;
  localparam int PIPE_EVERY = 2;
  localparam int NUM_TESTS  = 27;  // Reset, readback, 20 random, 3 saturation, 2 more.

  localparam logic [11:0] CTRL   = 12'h000;
  localparam logic [11:0] STATUS = 12'h004;
  localparam logic [11:0] RESULT = 12'h008;
  localparam logic [11:0] VEC    = 12'h100;
  localparam logic [11:0] WGT    = 12'h200;
  localparam logic [1:0]  OKAY   = 2'b00;
  localparam logic [1:0]  SLVERR = 2'b10;

  localparam logic [11:0] BAD_ADDR [5] = '{12'h00c, 12'h102, VEC + 12'(4 * VEC_LEN),
                                           WGT + 12'(4 * VEC_LEN), 12'h300};

  logic        clk;
  logic        reset;
  logic [11:0] awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [11:0] araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;

  integer             seed = 32'h05995eea;
  logic signed [15:0] vec_sh [VEC_LEN];
  logic signed [15:0] wgt_sh [VEC_LEN];
  logic [31:0]        exp_rdata;
  logic [1:0]         exp_rresp;
  logic [1:0]         exp_bresp;
  bit                 chk_rdata;
  bit                 wr_seen;
  bit                 rd_seen;

  vecmat_unit #(
    .VEC_LEN   (VEC_LEN),
    .PIPE_EVERY(PIPE_EVERY)
  ) dut (.*);

  always #2 clk = ~clk;

  function automatic void abort_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1);
  endfunction

  // ==============================
  // Checks
  // ==============================
  a_idle_b: assert property (@(posedge clk) disable iff (!reset) !wr_seen |-> !bvalid)
    else abort_run("Write response appeared before any write was issued.");
  a_idle_r: assert property (@(posedge clk) disable iff (!reset) !rd_seen |-> !rvalid)
    else abort_run("Read response appeared before any read was issued.");
  a_bresp: assert property (@(posedge clk) disable iff (!reset)
    bvalid && bready |-> bresp == exp_bresp)
    else abort_run($sformatf("ERR %0t bresp expected %h actual %h", $time, exp_bresp, bresp));
  a_rresp: assert property (@(posedge clk) disable iff (!reset)
    rvalid && rready |-> rresp == exp_rresp)
    else abort_run($sformatf("ERR %0t rresp expected %h actual %h", $time, exp_rresp, rresp));
  a_rdata: assert property (@(posedge clk) disable iff (!reset)
    rvalid && rready && chk_rdata |-> rdata == exp_rdata)
    else abort_run($sformatf("ERR %0t rdata expected %h actual %h", $time, exp_rdata, rdata));
  a_bhold: assert property (@(posedge clk) disable iff (!reset)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else abort_run("Write response changed while waiting for bready.");
  a_rhold: assert property (@(posedge clk) disable iff (!reset)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else abort_run("Read response changed while waiting for rready.");
  a_awpulse: assert property (@(posedge clk) disable iff (!reset) awready |=> !awready)
    else abort_run("awready stayed high for more than one cycle.");
  a_wready: assert property (@(posedge clk) disable iff (!reset) wready == awready)
    else abort_run($sformatf("ERR %0t wready expected %b actual %b", $time, awready, wready));

  // ==============================
  // Reference model
  // ==============================
  function automatic int clamp16(input int v, inout bit sat);
    if (v > 32767) begin
      sat = 1'b1;
      return 32767;
    end
    if (v < -32768) begin
      sat = 1'b1;
      return -32768;
    end
    return v;
  endfunction

  // Floor-shifted products, then pairwise sums with the odd node passed up.
  function automatic int model_dot(output bit sat);
    int node [VEC_LEN];
    int n;
    sat = 1'b0;
    for (int i = 0; i < VEC_LEN; i++) begin
      node[i] = clamp16((int'(vec_sh[i]) * int'(wgt_sh[i])) >>> 8, sat);
    end
    n = VEC_LEN;
    while (n > 1) begin
      for (int k = 0; k < (n + 1) / 2; k++) begin
        if (2 * k + 1 < n) begin
          node[k] = clamp16(node[2*k] + node[2*k+1], sat);
        end else begin
          node[k] = node[2*k];
        end
      end
      n = (n + 1) / 2;
    end
    return node[0];
  endfunction

  function automatic logic [31:0] sext32(input logic [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  // ==============================
  // Bus tasks
  // ==============================
  task automatic axil_write(input logic [11:0] addr, input logic [31:0] data,
                            input logic [1:0] resp, input int max_wait);
    int unsigned d;
    d = $unsigned($random(seed)) % (max_wait + 1);
    wr_seen   = 1'b1;
    exp_bresp = resp;
    awaddr    = addr;
    wdata     = data;
    awvalid   = 1'b1;
    wvalid    = 1'b1;
    do begin
      @(negedge clk);
    end while (!awready);
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    while (!bvalid) @(negedge clk);
    repeat (d) @(negedge clk);
    bready = 1'b1;
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic axil_read(input logic [11:0] addr, input logic [31:0] data_exp,
                           input logic [1:0] resp_exp, input bit chk,
                           output logic [31:0] data);
    int unsigned d;
    d = $unsigned($random(seed)) % 4;
    rd_seen   = 1'b1;
    exp_rdata = data_exp;
    exp_rresp = resp_exp;
    chk_rdata = chk;
    araddr    = addr;
    arvalid   = 1'b1;
    do begin
      @(negedge clk);
    end while (!arready);
    @(negedge clk);
    arvalid = 1'b0;
    while (!rvalid) @(negedge clk);
    repeat (d) @(negedge clk);
    data   = rdata;
    rready = 1'b1;
    @(negedge clk);
    rready = 1'b0;
  endtask

  task automatic load_operands();
    for (int i = 0; i < VEC_LEN; i++) begin
      axil_write(VEC + 12'(4 * i), sext32(vec_sh[i]), OKAY, 3);
      axil_write(WGT + 12'(4 * i), sext32(wgt_sh[i]), OKAY, 3);
    end
  endtask

  task automatic check_operands();
    logic [31:0] rd;
    for (int i = 0; i < VEC_LEN; i++) begin
      axil_read(VEC + 12'(4 * i), sext32(vec_sh[i]), OKAY, 1'b1, rd);
      axil_read(WGT + 12'(4 * i), sext32(wgt_sh[i]), OKAY, 1'b1, rd);
    end
  endtask

  task automatic small_operands();
    for (int i = 0; i < VEC_LEN; i++) begin
      vec_sh[i] = 16'($random(seed) % 513);  // -2.0 to 2.0.
      wgt_sh[i] = 16'($random(seed) % 513);
    end
  endtask

  task automatic poll_finish(input int expect_sum, input bit sat);
    logic [31:0] st;
    st = '0;
    while (!st[1]) begin
      axil_read(STATUS, 32'h0, OKAY, 1'b0, st);
    end
    axil_read(STATUS, sat ? 32'h6 : 32'h2, OKAY, 1'b1, st);
    axil_read(RESULT, expect_sum, OKAY, 1'b1, st);
  endtask

  task automatic run_dot(output int res);
    bit          sat;
    logic [31:0] st;
    res = model_dot(sat);
    fork
      axil_write(CTRL, 32'h1, OKAY, 3);
      begin
        @(negedge clk);
        axil_read(STATUS, 32'h1, OKAY, 1'b1, st);  // Busy only.
      end
    join
    poll_finish(res, sat);
  endtask

  // Second start lands while the tree is still busy.
  task automatic double_start(output int res);
    bit sat;
    res = model_dot(sat);
    axil_write(CTRL, 32'h1, OKAY, 0);
    axil_write(CTRL, 32'h1, OKAY, 3);
    poll_finish(res, sat);
  endtask

  // ==============================
  // Stimulus
  // ==============================
  initial begin
    logic [31:0] rd;
    int          last;
    clk     = 1'b0;
    reset   = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b1;

    axil_read(STATUS, 32'h0, OKAY, 1'b1, rd);
    axil_read(RESULT, 32'h0, OKAY, 1'b1, rd);
    axil_read(CTRL, 32'h0, OKAY, 1'b1, rd);
    for (int i = 0; i < VEC_LEN; i++) begin
      vec_sh[i] = '0;
      wgt_sh[i] = '0;
    end
    check_operands();

    for (int i = 0; i < VEC_LEN; i++) begin
      vec_sh[i] = 16'($random(seed));
      wgt_sh[i] = 16'($random(seed));
    end
    load_operands();
    check_operands();

    repeat (20) begin
      small_operands();
      load_operands();
      run_dot(last);
    end

    for (int i = 0; i < VEC_LEN; i++) begin
      vec_sh[i] = 16'h7fff;
      wgt_sh[i] = 16'h7fff;
    end
    load_operands();
    run_dot(last);
    for (int i = 0; i < VEC_LEN; i++) begin
      vec_sh[i] = i[0] ? 16'h8000 : 16'h7fff;
      wgt_sh[i] = (i % 3 == 0) ? 16'h8000 : 16'h7fff;
    end
    load_operands();
    run_dot(last);
    for (int i = 0; i < VEC_LEN; i++) begin
      vec_sh[i] = 16'h0100;  // 1.0 times 0.5.
      wgt_sh[i] = 16'h0080;
    end
    load_operands();
    run_dot(last);

    small_operands();
    load_operands();
    double_start(last);

    foreach (BAD_ADDR[j]) begin
      axil_read(BAD_ADDR[j], 32'h0, SLVERR, 1'b1, rd);
      axil_write(BAD_ADDR[j], 32'h0000_1234, SLVERR, 3);
    end
    check_operands();
    axil_read(RESULT, last, OKAY, 1'b1, rd);

    $display("sim passed");
    $finish;
  end

  initial begin
    repeat (NUM_TESTS * 200) @(posedge clk);
    abort_run("Watchdog expired before the tests finished.");
  end

endmodule

// ==== list.f ====
common/vecmat_pkg.sv
vecmat/vecmat_mul.sv
vecmat/vecmat_add.sv
src/axil_regs.sv
src/vecmat_unit.sv
tb/vecmat_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

LOG=sim.log

# Build testbench and DUT into one executable.
verilator --binary --assert -Wno-fatal -j 0 \
  --top-module vecmat_tb -f list.f -o vecmat_tb

# Exit status of the pipeline is the one of tee.
./obj_dir/vecmat_tb 2>&1 | tee "$LOG"

if grep -q "sim failed" "$LOG"; then
  echo "FAIL"
  exit 1
fi
if ! grep -q "sim passed" "$LOG"; then
  echo "FAIL: no result in log"
  exit 1
fi
echo "PASS"
